// File: Makefile
# Verilator build and run for the clock generator testbench

VERILATOR  ?= verilator
TOP        := tb_clkgen
RTL_TOP    := clkgen_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

SOURCES    := $(wildcard src/*.sv src/*.svh verif/*.sv)
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the log holds the pass line
run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
+incdir+src
src/clkgen_pkg.sv
src/clock_divider.sv
src/phase_shifter.sv
src/lock_detector.sv
src/clkgen_top.sv
verif/tb_clkgen.sv

// File: src/clkgen_cfg.svh
`ifndef CLKGEN_CFG_SVH
`define CLKGEN_CFG_SVH

// ############################
// Output lanes
// ############################

// Number of divided clock outputs
`define CLKGEN_NUM_OUT 6

// ############################
// Field widths
// ############################

// Divide code, lane divides by 2^code
`define CLKGEN_DIV_W 4

// Phase code, delay in whole clkin cycles
`define CLKGEN_PHASE_W 4

// Largest divide code the counters can serve
`define CLKGEN_MAX_DIV 8

// ############################
// Lock detection
// ############################

// Stable cycles after realign before locked rises
`define CLKGEN_LOCK_CYCLES 32

`endif

// File: src/clkgen_pkg.sv
`default_nettype none

`include "clkgen_cfg.svh"

package clkgen_pkg;

   // Divide code per lane
   // 0 holds the lane low, 1 to MAX_DIV divides by 2^n
   typedef logic [`CLKGEN_DIV_W-1:0] divcfg_t;

   // Phase code per lane, p adds p cycles of delay on top of the
   // single output register
   typedef logic [`CLKGEN_PHASE_W-1:0] phase_t;

   // Lock detector states
   typedef enum logic [1:0]
   {
      LK_OFF,
      LK_WAIT,
      LK_LOCKED
   } lock_state_t;

endpackage

`default_nettype wire

// File: src/clkgen_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_cfg.svh"

module clkgen_top import clkgen_pkg::*;
(
   input  logic                          clkin,
   input  logic                          arst_n,
   input  logic                          pwrdwn,
   input  divcfg_t [`CLKGEN_NUM_OUT-1:0] divcfg,
   input  phase_t  [`CLKGEN_NUM_OUT-1:0] phase,
   output logic    [`CLKGEN_NUM_OUT-1:0] clkout,
   output logic                          locked
);

   // ############################
   // Shared control
   // ############################

   logic                          realign;
   logic                          run;
   divcfg_t [`CLKGEN_NUM_OUT-1:0] divcfg_hold;
   phase_t  [`CLKGEN_NUM_OUT-1:0] phase_hold;

   // Snapshots the config and paces every lane
   lock_detector u_lock_detector
   (
      .clkin       (clkin),
      .arst_n      (arst_n),
      .pwrdwn      (pwrdwn),
      .divcfg      (divcfg),
      .phase       (phase),
      .realign     (realign),
      .run         (run),
      .locked      (locked),
      .divcfg_hold (divcfg_hold),
      .phase_hold  (phase_hold)
   );

   // ############################
   // Output lanes
   // ############################

   // Divider level into each lane's delay line
   logic [`CLKGEN_NUM_OUT-1:0] div_out;

   genvar i;
   generate
      for (i = 0; i < `CLKGEN_NUM_OUT; i = i + 1)
      begin : g_lane
         // 2^n divide from clkin
         clock_divider u_clock_divider
         (
            .clkin   (clkin),
            .arst_n  (arst_n),
            .realign (realign),
            .run     (run),
            .divcfg  (divcfg_hold[i]),
            .div_out (div_out[i])
         );

         // Whole-cycle phase delay
         phase_shifter u_phase_shifter
         (
            .clkin   (clkin),
            .arst_n  (arst_n),
            .realign (realign),
            .run     (run),
            .phase   (phase_hold[i]),
            .div_in  (div_out[i]),
            .clkout  (clkout[i])
         );
      end
   endgenerate

endmodule

`default_nettype wire

// File: src/clock_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_cfg.svh"

module clock_divider import clkgen_pkg::*;
(
   input  logic    clkin,
   input  logic    arst_n,
   input  logic    realign,
   input  logic    run,
   input  divcfg_t divcfg,
   output logic    div_out
);

   // ############################
   // Free-running counter
   // ############################

   logic [`CLKGEN_MAX_DIV-1:0] count;

   // Cleared on realign so every lane starts from the same edge
   always_ff @(posedge clkin or negedge arst_n)
   begin
      if (!arst_n)
      begin
         count <= '0;
      end
      else if (realign || !run)
      begin
         count <= '0;
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   // ############################
   // Output bit select
   // ############################

   logic [`CLKGEN_DIV_W-1:0]   bit_sel;
   logic [`CLKGEN_MAX_DIV-1:0] count_sh;

   // Code n picks counter bit n-1, giving period 2^n at 50% duty
   assign bit_sel  = divcfg - 1'b1;
   assign count_sh = count >> bit_sel;

   // Code 0 disables the lane
   assign div_out = run & (divcfg != '0) & count_sh[0];

   // Held code from the lock detector stays in range while running
   a_divcfg_range : assert property (
      @(posedge clkin) disable iff (!arst_n)
      run |-> (divcfg <= `CLKGEN_MAX_DIV)
   );

endmodule

`default_nettype wire

// File: src/lock_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_cfg.svh"

module lock_detector import clkgen_pkg::*;
(
   input  logic                          clkin,
   input  logic                          arst_n,
   input  logic                          pwrdwn,
   input  divcfg_t [`CLKGEN_NUM_OUT-1:0] divcfg,
   input  phase_t  [`CLKGEN_NUM_OUT-1:0] phase,
   output logic                          realign,
   output logic                          run,
   output logic                          locked,
   output divcfg_t [`CLKGEN_NUM_OUT-1:0] divcfg_hold,
   output phase_t  [`CLKGEN_NUM_OUT-1:0] phase_hold
);

   localparam int CNT_W = $clog2(`CLKGEN_LOCK_CYCLES);

   lock_state_t      state;
   logic [CNT_W-1:0] stable_cnt;
   logic             cfg_changed;
   logic             take_snap;

   // ############################
   // Change detection
   // ############################

   assign cfg_changed = (divcfg != divcfg_hold) || (phase != phase_hold);

   // Leaving power-down, or a new config once running.
   // A change during the realign cycle is picked up one cycle later
   assign take_snap = !pwrdwn &&
                      ((state == LK_OFF) || (cfg_changed && !realign));

   // Lanes only ever see this copy
   always_ff @(posedge clkin)
   begin
      if (take_snap)
      begin
         divcfg_hold <= divcfg;
         phase_hold  <= phase;
      end
   end

   // ############################
   // Lock FSM
   // ############################

   always_ff @(posedge clkin or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state      <= LK_OFF;
         realign    <= 1'b0;
         run        <= 1'b0;
         locked     <= 1'b0;
         stable_cnt <= '0;
      end
      else
      begin
         realign <= 1'b0;
         if (pwrdwn)
         begin
            state  <= LK_OFF;
            run    <= 1'b0;
            locked <= 1'b0;
         end
         else if (take_snap)
         begin
            state      <= LK_WAIT;
            realign    <= 1'b1;
            run        <= 1'b1;
            locked     <= 1'b0;
            stable_cnt <= '0;
         end
         else if (state == LK_WAIT)
         begin
            // Count from the first edge after the realign cycle
            if (stable_cnt == CNT_W'(`CLKGEN_LOCK_CYCLES - 1))
            begin
               state  <= LK_LOCKED;
               locked <= 1'b1;
            end
            else
            begin
               stable_cnt <= stable_cnt + 1'b1;
            end
         end
      end
   end

   a_locked_state : assert property (
      @(posedge clkin) disable iff (!arst_n)
      locked |-> (state == LK_LOCKED)
   );

   // Lanes need a clean single-cycle restart
   a_realign_pulse : assert property (
      @(posedge clkin) disable iff (!arst_n)
      realign |=> !realign
   );

endmodule

`default_nettype wire

// File: src/phase_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_cfg.svh"

module phase_shifter import clkgen_pkg::*;
(
   input  logic   clkin,
   input  logic   arst_n,
   input  logic   realign,
   input  logic   run,
   input  phase_t phase,
   input  logic   div_in,
   output logic   clkout
);

   localparam int DEPTH = 2 ** `CLKGEN_PHASE_W;

   // ############################
   // Delay line
   // ############################

   // The output register is the last stage, so the line
   // itself holds one stage less than the full depth
   logic [DEPTH-2:0] shift_q;
   logic [DEPTH-1:0] taps;
   logic             tap_q;

   // Tap 0 is the undelayed divider level
   assign taps = {shift_q, div_in};

   always_ff @(posedge clkin or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shift_q <= '0;
         tap_q   <= 1'b0;
      end
      else if (realign || !run)
      begin
         // Flush old waveform so the lane restarts from k = 1
         shift_q <= '0;
         tap_q   <= 1'b0;
      end
      else
      begin
         shift_q <= {shift_q[DEPTH-3:0], div_in};
         tap_q   <= taps[phase];
      end
   end

   // Quiet during realign and power-down
   assign clkout = tap_q & run & ~realign;

   // A stopped lane is silent and its delay line empties one cycle later
   a_quiet_when_stopped : assert property (
      @(posedge clkin) disable iff (!arst_n)
      !run |-> !clkout ##1 ((shift_q == '0) && !tap_q)
   );

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_cfg.svh"

module tb_clkgen import clkgen_pkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int NUM_OUT    = `CLKGEN_NUM_OUT;
   localparam int PHASE_MAX  = (2 ** `CLKGEN_PHASE_W) - 1;

   // Test lengths in clkin cycles
   localparam int RESET_TEST_LEN  = 20;
   localparam int LOCK_TEST_LEN   = 600;
   localparam int PHASE_TEST_LEN  = 300;
   localparam int CHANGE_TEST_LEN = 400;
   localparam int POWER_TEST_LEN  = 660;
   localparam int TOTAL_LEN       = RESET_TEST_LEN + LOCK_TEST_LEN + PHASE_TEST_LEN +
                                    CHANGE_TEST_LEN + POWER_TEST_LEN;
   localparam int TIMEOUT_CYCLES  = TOTAL_LEN + TOTAL_LEN / 5;

   // ############################
   // DUT signals
   // ############################

   logic                   clkin;
   logic                   arst_n;
   logic                   pwrdwn;
   divcfg_t [NUM_OUT-1:0]  divcfg;
   phase_t  [NUM_OUT-1:0]  phase;
   logic    [NUM_OUT-1:0]  clkout;
   logic                   locked;

   // Model of the expected lane state
   logic                   check_en  = 1'b0;
   logic                   m_running = 1'b0;
   int                     m_k       = 0;
   divcfg_t [NUM_OUT-1:0]  m_divcfg  = '0;
   phase_t  [NUM_OUT-1:0]  m_phase   = '0;

   // Scoreboard
   int    check_count       = 0;
   int    error_count       = 0;
   int    test_errors_start = 0;
   int    test_checks_start = 0;
   int    tests_run         = 0;
   int    tests_failed      = 0;
   int    cycle_count       = 0;
   string test_name;

   always #(CLK_PERIOD / 2) clkin = ~clkin;

   clkgen_top UUT
   (
      .clkin  (clkin),
      .arst_n (arst_n),
      .pwrdwn (pwrdwn),
      .divcfg (divcfg),
      .phase  (phase),
      .clkout (clkout),
      .locked (locked)
   );

   // ############################
   // Reference and compare
   // ############################

   // Level of one lane k edges after the realign cycle
   function automatic logic expected_clkout(input divcfg_t n, input phase_t p, input int k);
      int idx;
      int bit_pos;
      idx     = k - 1 - (int'(p) + 1);
      bit_pos = int'(n) - 1;
      if ((n == '0) || (idx < 0))
      begin
         return 1'b0;
      end
      return idx[bit_pos];
   endfunction

   task automatic compare_clkout(input int lane, input logic actual, input logic expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Mismatch at %0d ns: clkout[%0d] actual %b expected %b",
                  $time, lane, actual, expected);
      end
   endtask

   task automatic compare_locked(input logic actual, input logic expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Mismatch at %0d ns: locked actual %b expected %b",
                  $time, actual, expected);
      end
   endtask

   // Tracks k from what the testbench itself drove before each edge
   always @(posedge clkin)
   begin
      check_en = 1'b1;
      if (!arst_n || pwrdwn)
      begin
         m_running = 1'b0;
         m_k       = 0;
      end
      else if (!m_running || (divcfg != m_divcfg) || (phase != m_phase))
      begin
         // New snapshot, this edge starts the realign cycle
         m_divcfg  = divcfg;
         m_phase   = phase;
         m_running = 1'b1;
         m_k       = 0;
      end
      else
      begin
         m_k = m_k + 1;
      end
   end

   // Outputs are settled by the falling edge
   always @(negedge clkin)
   begin
      if (check_en)
      begin
         for (int i = 0; i < NUM_OUT; i++)
         begin
            compare_clkout(i, clkout[i],
                           m_running & expected_clkout(m_divcfg[i], m_phase[i], m_k));
         end
         compare_locked(locked, m_running && (m_k >= `CLKGEN_LOCK_CYCLES));
      end
   end

   // ############################
   // Stimulus helpers
   // ############################

   task automatic run_cycles(input int n);
      repeat (n) @(posedge clkin);
   endtask

   task automatic drive_random_config();
      for (int i = 0; i < NUM_OUT; i++)
      begin
         divcfg[i] <= divcfg_t'($urandom_range(`CLKGEN_MAX_DIV, 0));
         phase[i]  <= phase_t'($urandom_range(PHASE_MAX, 0));
      end
   endtask

   // Same divide on every lane, phases spread two cycles apart
   task automatic drive_equal_divides(input divcfg_t n, input phase_t base);
      for (int i = 0; i < NUM_OUT; i++)
      begin
         divcfg[i] <= n;
         phase[i]  <= phase_t'((int'(base) + 2 * i) % (PHASE_MAX + 1));
      end
   endtask

   task automatic change_lane_divide(input int lane);
      divcfg_t next_code;
      if (divcfg[lane] >= divcfg_t'(`CLKGEN_MAX_DIV))
      begin
         next_code = '0;
      end
      else
      begin
         next_code = divcfg[lane] + 1'b1;
      end
      divcfg[lane] <= next_code;
   endtask

   // Wraps, so the code always differs
   task automatic change_lane_phase(input int lane);
      phase[lane] <= phase[lane] + 1'b1;
   endtask

   task automatic begin_test(input string name);
      test_name         = name;
      test_errors_start = error_count;
      test_checks_start = check_count;
   endtask

   task automatic end_test();
      int errs;
      int chks;
      errs = error_count - test_errors_start;
      chks = check_count - test_checks_start;
      tests_run++;
      if (errs != 0)
      begin
         tests_failed++;
      end
      $display("Test %0d %s: %0d checks, %0d errors", tests_run, test_name, chks, errs);
   endtask

   // ############################
   // Test sequence
   // ############################

   initial
   begin
      clkin  = 1'b0;
      arst_n = 1'b0;
      pwrdwn = 1'b1;
      divcfg = '0;
      phase  = '0;
      void'($urandom(32'hff11a5e6));

      // Outputs quiet through reset and while powered down
      begin_test("reset_idle");
      repeat (3) @(posedge clkin);
      arst_n <= 1'b1;
      drive_random_config();
      run_cycles(RESET_TEST_LEN - 3);
      end_test();

      begin_test("lock_and_divide");
      drive_random_config();
      pwrdwn <= 1'b0;
      run_cycles(LOCK_TEST_LEN);
      end_test();

      begin_test("phase_offsets");
      drive_equal_divides(divcfg_t'($urandom_range(4, 1)),
                          phase_t'($urandom_range(PHASE_MAX, 0)));
      run_cycles(PHASE_TEST_LEN);
      end_test();

      // Each change lands well after lock
      begin_test("single_lane_change");
      change_lane_divide(int'($urandom_range(NUM_OUT - 1, 0)));
      run_cycles(CHANGE_TEST_LEN / 2);
      change_lane_phase(int'($urandom_range(NUM_OUT - 1, 0)));
      run_cycles(CHANGE_TEST_LEN / 2);
      end_test();

      begin_test("powerdown_restart");
      pwrdwn <= 1'b1;
      run_cycles(20);
      drive_random_config();
      run_cycles(40);
      pwrdwn <= 1'b0;
      run_cycles(POWER_TEST_LEN - 60);
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, error_count);
      if ((error_count == 0) && (tests_failed == 0))
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Run limit from the summed test lengths
   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clkin);
         cycle_count++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
